// File: Bender.yml
package:
  name: decoder8b10b

export_include_dirs:
  - .

sources:
  - codeGroupPkg.sv
  - lineStatusPkg.sv
  - subBlockIf.sv
  - subBlockClassifier.sv
  - symbolMapper.sv
  - codeViolationCheck.sv
  - disparityTracker.sv
  - decoder8b10b.sv
  - target: test
    files:
      - tbDecoder8b10b.sv

// File: codeGroupPkg.sv
`default_nettype none

`include "decoder8b10b_macros.svh"

package codeGroupPkg;

  // 6-bit sub-block with bits a b c d e i from MSB down
  typedef logic [`SUB6_WIDTH-1:0] sub6_t;

  // 4-bit sub-block with bits f g h j from MSB down
  typedef logic [`SUB4_WIDTH-1:0] sub4_t;

  // Ten-bit code group as it arrives on the TBI
  // Bit a is sent first and sits at the MSB
  typedef struct packed {
    sub6_t abcdei;
    sub4_t fghj;
  } codeGroup_t;

  // Decoded byte with bits H G F E D C B A from MSB down
  // Low five bits are EDCBA (x), high three are HGF (y)
  typedef logic [`BYTE_WIDTH-1:0] decodedByte_t;

endpackage

`default_nettype wire

// File: codeViolationCheck.sv
`timescale 1ns/10ps
`default_nettype none

`include "decoder8b10b_macros.svh"

module codeViolationCheck
(
  input  wire                           RBYTECLK,
  input  wire                           reset,
  input  wire codeGroupPkg::codeGroup_t tbi_i,
  subBlockIf.sink                       sb_i,
  output logic                          codingErr_o
);

  logic a, b, c, d, e, i;
  logic f, g, h, j;
  logic cerr1, cerr2, cerr3, cerr4, cerr5, cerr6, cerr7, cerr8, cerr9;
  logic zerr2, zerr3;
  logic patentErr, subBlockErr;
  logic patentErrQ, subBlockErrQ;

  assign {a, b, c, d, e, i} = tbi_i.abcdei;
  assign {f, g, h, j} = tbi_i.fghj;

  // ************************************************************
  // Patent coding-error terms
  // ************************************************************

  // abcd all ones or all zeros
  assign cerr1 = (a & b & c & d) | (~a & ~b & ~c & ~d);
  // Single one in abcd with ei low leaves too few ones
  assign cerr2 = sb_i.p13 & ~e & ~i;
  assign cerr3 = sb_i.p31 & e & i;
  // fghj all ones or all zeros
  assign cerr4 = (f & g & h & j) | (~f & ~g & ~h & ~j);
  // Run of five across the sub-block boundary
  assign cerr5 = (e & i & f & g & h) | (~e & ~i & ~f & ~g & ~h);
  assign cerr6 = (e & ~i & g & h & j) | (~e & i & ~g & ~h & ~j);
  // ei and ghj opposite is only legal behind a cde run
  assign cerr7 = ((e & i & ~g & ~h & ~j) | (~e & ~i & g & h & j)) &
                 ~((c & d & e) | (~c & ~d & ~e));
  // Alternate .7 without the matching abcd class
  assign cerr8 = ~sb_i.p31 & e & ~i & ~g & ~h & ~j;
  assign cerr9 = ~sb_i.p13 & ~e & i & g & h & j;

  assign patentErr = cerr1 | cerr2 | cerr3 | cerr4 | cerr5 |
                     cerr6 | cerr7 | cerr8 | cerr9;

  // ************************************************************
  // Sub-block disparity coding errors
  // ************************************************************

  // 1100 only follows a negative or balanced 6-bit block
  assign zerr2 = f & g & ~h & ~j & sb_i.disp6p;
  // 0011 only follows a positive or balanced 6-bit block
  assign zerr3 = ~f & ~g & h & j & sb_i.disp6n;

  assign subBlockErr = sb_i.subBlockConflict | zerr2 | zerr3;

  // Two parallel flag registers, merged at the output
  always_ff @(posedge RBYTECLK or negedge reset)
  begin
    if (!reset)
    begin
      patentErrQ   <= `ERR_RESET_VALUE;
      subBlockErrQ <= `ERR_RESET_VALUE;
    end
    else
    begin
      patentErrQ   <= patentErr;
      subBlockErrQ <= subBlockErr;
    end
  end

  assign codingErr_o = patentErrQ | subBlockErrQ;

  // An abcd in no ones-count class is all ones or all zeros
  // Such a group always reaches the output one cycle later
  abcdRunFlagged: assert property (@(posedge RBYTECLK) disable iff (!reset)
    !(sb_i.p22 || sb_i.p13 || sb_i.p31) |=> codingErr_o);

endmodule

`default_nettype wire

// File: decoder8b10b.sv
`timescale 1ns/10ps
`default_nettype none

`include "decoder8b10b_macros.svh"

module decoder8b10b
(
  input  wire                    RBYTECLK,
  input  wire                    reset,
  input  wire [`TBI_WIDTH-1:0]   tbi_i,
  output logic                   kOut_o,
  output logic [`BYTE_WIDTH-1:0] ebi_o,
  output logic                   codingErr_o,
  output logic                   disparity_o,
  output logic                   disparityErr_o
);

  // Raw TBI group split into its sub-blocks
  codeGroupPkg::codeGroup_t tbiGroup;
  // Error status of the decoded group
  lineStatusPkg::lineErr_t  lineErr;

  subBlockIf sbBus ();

  assign tbiGroup = tbi_i;

  // ************************************************************
  // Decoder datapath
  // ************************************************************

  subBlockClassifier uClassifier (
    .tbi_i (tbiGroup),
    .sb_o  (sbBus)
  );

  symbolMapper uMapper (
    .RBYTECLK (RBYTECLK),
    .reset    (reset),
    .tbi_i    (tbiGroup),
    .sb_i     (sbBus),
    .ebi_o    (ebi_o),
    .kOut_o   (kOut_o)
  );

  codeViolationCheck uCodeCheck (
    .RBYTECLK    (RBYTECLK),
    .reset       (reset),
    .tbi_i       (tbiGroup),
    .sb_i        (sbBus),
    .codingErr_o (lineErr.codingErr)
  );

  disparityTracker uDispTracker (
    .RBYTECLK       (RBYTECLK),
    .reset          (reset),
    .sb_i           (sbBus),
    .tbi_i          (tbiGroup),
    .disparity_o    (disparity_o),
    .disparityErr_o (lineErr.disparityErr)
  );

  // Error flags leave as plain ports
  assign codingErr_o    = lineErr.codingErr;
  assign disparityErr_o = lineErr.disparityErr;

endmodule

`default_nettype wire

// File: decoder8b10b_macros.svh
`ifndef DECODER8B10B_MACROS_SVH
`define DECODER8B10B_MACROS_SVH

// ************************************************************
// Code group and byte widths
// ************************************************************

// Full TBI code group abcdei fghj
`define TBI_WIDTH 10
// First sub-block abcdei
`define SUB6_WIDTH 6
// Second sub-block fghj
`define SUB4_WIDTH 4
// Decoded byte HGFEDCBA
`define BYTE_WIDTH 8

// ************************************************************
// Reset values
// ************************************************************

// Both error flags stay set until the first decoded group
`define ERR_RESET_VALUE 1'b1
// Decoded byte after reset
`define BYTE_RESET_VALUE {`BYTE_WIDTH{1'b0}}

`endif

// File: disparityTracker.sv
`timescale 1ns/10ps
`default_nettype none

`include "decoder8b10b_macros.svh"

module disparityTracker
(
  input  wire                           RBYTECLK,
  input  wire                           reset,
  subBlockIf.sink                       sb_i,
  input  wire codeGroupPkg::codeGroup_t tbi_i,
  output logic                          disparity_o,
  output logic                          disparityErr_o
);

  lineStatusPkg::rdState_e rdState, rdNext;

  logic rdPos;
  logic a, b, c, d, e, i, f, g;
  logic disp6a, disp6a2, disp6a0, disp6b;
  logic derr1, derr2, derr3, derr4, derr5, derr6, derr7, derr8;
  logic derr12, derr34, derr56, derr78;

  assign a = tbi_i.abcdei[5];
  assign b = tbi_i.abcdei[4];
  assign c = tbi_i.abcdei[3];
  assign d = tbi_i.abcdei[2];
  assign e = tbi_i.abcdei[1];
  assign i = tbi_i.abcdei[0];
  assign f = tbi_i.fghj[3];
  assign g = tbi_i.fghj[2];

  // Current disparity as a bit
  assign rdPos = (rdState == lineStatusPkg::RD_POS);

  // ************************************************************
  // Running disparity FSM
  // ************************************************************

  // Disparity after abcd, given the disparity at group start
  assign disp6a  = sb_i.p31 | (sb_i.p22 & rdPos);
  // Already two up after abcd
  assign disp6a2 = sb_i.p31 & rdPos;
  // Already two down after abcd
  assign disp6a0 = sb_i.p13 & ~rdPos;

  // Disparity at the end of the 6-bit sub-block
  // 000111 always ends positive and 111000 always ends negative
  assign disp6b = ((e & i & ~disp6a0) | (disp6a & (e | i)) | disp6a2 | (e & i & d)) &
                  (e | i | d);

  // Positive fghj sets RD+, balanced fghj keeps the 6-bit result
  always_comb
  begin
    if (sb_i.fghjP31 | (disp6b & sb_i.fghj22))
      rdNext = lineStatusPkg::RD_POS;
    else
      rdNext = lineStatusPkg::RD_NEG;
  end

  // ************************************************************
  // Disparity-error terms
  // ************************************************************

  // 6-bit block of the wrong sign
  assign derr1 = (rdPos & sb_i.disp6p) | (sb_i.disp6n & ~rdPos);
  // Still positive going into fg = 11
  assign derr2 = rdPos & ~sb_i.disp6n & f & g;
  assign derr3 = rdPos & a & b & c;
  assign derr4 = rdPos & ~sb_i.disp6n & sb_i.fghjP31;
  // Mirror terms for negative disparity
  assign derr5 = ~rdPos & ~sb_i.disp6p & ~f & ~g;
  assign derr6 = ~rdPos & ~a & ~b & ~c;
  assign derr7 = ~rdPos & ~sb_i.disp6p & sb_i.fghjP13;
  assign derr8 = sb_i.subBlockConflict;

  always_ff @(posedge RBYTECLK or negedge reset)
  begin
    if (!reset)
    begin
      rdState <= lineStatusPkg::RD_NEG;
      derr12  <= `ERR_RESET_VALUE;
      derr34  <= `ERR_RESET_VALUE;
      derr56  <= `ERR_RESET_VALUE;
      derr78  <= `ERR_RESET_VALUE;
    end
    else
    begin
      rdState <= rdNext;
      derr12  <= derr1 | derr2;
      derr34  <= derr3 | derr4;
      derr56  <= derr5 | derr6;
      derr78  <= derr7 | derr8;
    end
  end

  assign disparity_o    = rdPos;
  assign disparityErr_o = derr12 | derr34 | derr56 | derr78;

  // X on the TBI must not leak into the disparity state
  rdStateKnown: assert property (@(posedge RBYTECLK) disable iff (!reset)
    !$isunknown(rdState));

endmodule

`default_nettype wire

// File: files.f
+incdir+.
codeGroupPkg.sv
lineStatusPkg.sv
subBlockIf.sv
subBlockClassifier.sv
symbolMapper.sv
codeViolationCheck.sv
disparityTracker.sv
decoder8b10b.sv
tbDecoder8b10b.sv

// File: lineStatusPkg.sv
`default_nettype none

package lineStatusPkg;

  // Running disparity of the line
  // Encoding matches the disparity output bit
  typedef enum logic {
    RD_NEG = 1'b0,
    RD_POS = 1'b1
  } rdState_e;

  // Error status of one decoded code group
  typedef struct packed {
    // Illegal code group
    logic codingErr;
    // Legal group sent with the wrong running disparity
    logic disparityErr;
  } lineErr_t;

endpackage

`default_nettype wire

// File: subBlockClassifier.sv
`timescale 1ns/10ps
`default_nettype none

module subBlockClassifier
(
  input  wire codeGroupPkg::codeGroup_t tbi_i,
  subBlockIf.source                     sb_o
);

  logic a, b, c, d, e, i;
  logic f, g, h, j;
  logic aEqB, cEqD, fEqG, hEqJ;
  logic p22, p13, p31;
  logic fghjP13, fghjP31;
  logic disp6p, disp6n;

  assign {a, b, c, d, e, i} = tbi_i.abcdei;
  assign {f, g, h, j} = tbi_i.fghj;

  // ************************************************************
  // abcd ones count
  // ************************************************************

  assign aEqB = (a == b);
  assign cEqD = (c == d);

  // Two ones in abcd
  assign p22 = (a & b & ~c & ~d) | (c & d & ~a & ~b) | (~aEqB & ~cEqD);
  // Single one in abcd
  assign p13 = (~aEqB & ~c & ~d) | (~cEqD & ~a & ~b);
  // Three ones in abcd
  assign p31 = (~aEqB & c & d) | (~cEqD & a & b);

  // ************************************************************
  // fghj balance
  // ************************************************************

  assign fEqG = (f == g);
  assign hEqJ = (h == j);

  // Negative 4-bit sub-block, one ones bit
  assign fghjP13 = (~fEqG & ~h & ~j) | (~hEqJ & ~f & ~g);
  // Positive 4-bit sub-block, three ones bits
  assign fghjP31 = (~fEqG & h & j) | (~hEqJ & f & g);

  // ************************************************************
  // 6-bit disparity and same-sign conflict
  // ************************************************************

  // ei pushes abcd to an unbalanced 6-bit result
  assign disp6p = (p31 & (e | i)) | (p22 & e & i);
  assign disp6n = (p13 & ~(e & i)) | (p22 & ~e & ~i);

  assign sb_o.p22     = p22;
  assign sb_o.p13     = p13;
  assign sb_o.p31     = p31;
  assign sb_o.fghjP13 = fghjP13;
  assign sb_o.fghjP31 = fghjP31;
  // Balanced fghj
  assign sb_o.fghj22  = (f & g & ~h & ~j) | (~f & ~g & h & j) | (~fEqG & ~hEqJ);
  assign sb_o.disp6p  = disp6p;
  assign sb_o.disp6n  = disp6n;

  // An unbalanced group never has two sub-blocks of the same sign
  assign sb_o.subBlockConflict = (disp6p & fghjP31) | (disp6n & fghjP13);

endmodule

`default_nettype wire

// File: subBlockIf.sv
`timescale 1ns/10ps
`default_nettype none

// Sub-block classes shared by the mapper and both checkers
interface subBlockIf;

  // Ones count in abcd
  logic p22;
  logic p13;
  logic p31;

  // Balance classes of fghj
  logic fghjP13;
  logic fghjP31;
  logic fghj22;

  // Disparity of the 6-bit sub-block
  logic disp6p;
  logic disp6n;

  // Both sub-blocks unbalanced in the same direction
  logic subBlockConflict;

  modport source (
    output p22, p13, p31,
    output fghjP13, fghjP31, fghj22,
    output disp6p, disp6n, subBlockConflict
  );

  modport sink (
    input p22, p13, p31,
    input fghjP13, fghjP31, fghj22,
    input disp6p, disp6n, subBlockConflict
  );

endinterface

`default_nettype wire

// File: symbolMapper.sv
`timescale 1ns/10ps
`default_nettype none

`include "decoder8b10b_macros.svh"

module symbolMapper
(
  input  wire                        RBYTECLK,
  input  wire                        reset,
  input  wire codeGroupPkg::codeGroup_t tbi_i,
  subBlockIf.sink                    sb_i,
  output codeGroupPkg::decodedByte_t ebi_o,
  output logic                       kOut_o
);

  logic a, b, c, d, e, i;
  logic f, g, h, j;
  logic eEqI;
  logic cdeiOnes, cdeiZeros;
  logic p22acEqI, p22ancnEqI, p22bcEqI, p22bncnEqI;
  logic anbnenin, abei, p13dei, p13in, p13en, p31i;
  logic comp1, comp2, comp3, comp4, comp5, comp6, comp7;
  logic decA, decB, decC, decD, decE;
  logic decF, decG, decH;
  logic k28p;
  logic kA, kB, kC, kFlag;
  logic kFormOk;

  assign {a, b, c, d, e, i} = tbi_i.abcdei;
  assign {f, g, h, j} = tbi_i.fghj;

  assign eEqI      = (e == i);
  assign cdeiOnes  = c & d & e & i;
  assign cdeiZeros = ~c & ~d & ~e & ~i;

  // ************************************************************
  // 5b/6b decode
  // ************************************************************

  // Product terms where ABCDE differs from abcde
  assign p22acEqI   = sb_i.p22 & a & c & eEqI;
  assign p22ancnEqI = sb_i.p22 & ~a & ~c & eEqI;
  assign p22bcEqI   = sb_i.p22 & b & c & eEqI;
  assign p22bncnEqI = sb_i.p22 & ~b & ~c & eEqI;
  assign anbnenin   = ~a & ~b & ~e & ~i;
  assign abei       = a & b & e & i;
  assign p13dei     = sb_i.p13 & d & e & i;
  assign p13in      = sb_i.p13 & ~i;
  assign p13en      = sb_i.p13 & ~e;
  assign p31i       = sb_i.p31 & i;

  // Seven complement groups, each shared by several output bits
  assign comp1 = p22ancnEqI | p13en;
  assign comp2 = abei | cdeiZeros | p31i;
  assign comp3 = p31i | p22bcEqI | p13dei;
  assign comp4 = p22acEqI | p13en;
  assign comp5 = p13en | cdeiZeros | anbnenin;
  assign comp6 = p22ancnEqI | p13in;
  assign comp7 = p13dei | p22bncnEqI;

  // Selective inversion of abcde
  assign decA = a ^ (comp7 | comp1 | comp2);
  assign decB = b ^ (comp2 | comp3 | comp4);
  assign decC = c ^ (comp1 | comp3 | comp5);
  assign decD = d ^ (comp2 | comp4 | comp7);
  assign decE = e ^ (comp5 | comp6 | comp7);

  // ************************************************************
  // 3b/4b decode and K detection
  // ************************************************************

  // K28 in positive disparity flips the meaning of fghj for .1 .2 .5 .6
  assign k28p = cdeiZeros;

  assign decF = (j & ~f & (h | ~g | k28p)) | (f & ~j & (~h | g | ~k28p)) |
                (k28p & g & h) | (~k28p & ~g & ~h);
  assign decG = (j & ~f & (h | ~g | ~k28p)) | (f & ~j & (~h | g | k28p)) |
                (~k28p & g & h) | (k28p & ~g & ~h);
  assign decH = ((j ^ h) & ~((~f & g & ~h & j & ~k28p) | (~f & g & h & ~j & k28p) |
                             (f & ~g & ~h & j & ~k28p) | (f & ~g & h & ~j & k28p))) |
                (~f & g & h & j) | (f & ~g & ~h & ~j);

  // K28.x
  assign kA = cdeiOnes | cdeiZeros;
  // Kx.7 in positive and negative disparity
  assign kB = sb_i.p13 & ~e & i & g & h & j;
  assign kC = sb_i.p31 & e & ~i & ~g & ~h & ~j;
  assign kFlag = kA | kB | kC;

  always_ff @(posedge RBYTECLK or negedge reset)
  begin
    if (!reset)
    begin
      kOut_o <= 1'b0;
      ebi_o  <= `BYTE_RESET_VALUE;
    end
    else
    begin
      kOut_o <= kFlag;
      ebi_o  <= {decH, decG, decF, decE, decD, decC, decB, decA};
    end
  end

  // K28 needs a balanced abcd, and an all-equal fghj is never a K group
  assign kFormOk = (sb_i.p22 | ~kA) & (f | g | h | j) & ~(f & g & h & j);

  // Well-formed K groups only decode to K28.x or K23/K27/K29/K30.7
  kByteLegal: assert property (@(posedge RBYTECLK) disable iff (!reset)
    (kOut_o && $past(kFormOk)) |->
      ((ebi_o[4:0] == 5'd28) ||
       ((ebi_o[7:5] == 3'b111) && (ebi_o[4:0] inside {5'd23, 5'd27, 5'd29, 5'd30}))));

endmodule

`default_nettype wire

// File: tbCodeTables.svh
`ifndef TB_CODE_TABLES_SVH
`define TB_CODE_TABLES_SVH

// ************************************************************
// Reference 8b/10b encoder tables, RD- column
// ************************************************************

// 5b/6b code abcdei for D.0 up to D.31, D.0 leftmost
localparam logic [191:0] SIX_NEG_TABLE = {
  6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
  6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
  6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
  6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
};

// K28 differs from D.28 in the i bit
localparam logic [5:0] K28_SIX_NEG = 6'b001111;

// 3b/4b code fghj for D.x.0 up to D.x.7, primary .7
localparam logic [31:0] FOUR_DATA_NEG_TABLE = {
  4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
};
// Alternate D.x.7
localparam logic [3:0] ALT7_NEG = 4'b0111;

// 3b/4b code fghj for K.x.0 up to K.x.7
localparam logic [31:0] FOUR_K_NEG_TABLE = {
  4'b1011, 4'b0110, 4'b1010, 4'b1100, 4'b1101, 4'b0101, 4'b1001, 4'b0111
};

// ************************************************************
// Random bytes
// ************************************************************

int unsigned lcgState = 32'd67734;

function automatic logic [7:0] nextRandomByte();
  lcgState = lcgState * 32'd1664525 + 32'd1013904223;
  // Upper bits of an LCG are the better mixed ones
  return lcgState[23:16];
endfunction

// ************************************************************
// Encoder with running disparity
// ************************************************************

function automatic logic [9:0] encodeGroup(
  input  logic [7:0] byteVal,
  input  logic       isK,
  input  logic       rdIn,
  output logic       rdOut
);
  logic [4:0] x;
  logic [2:0] y;
  logic [5:0] six;
  logic [3:0] four;
  logic       rdMid;
  logic       useAlt;

  x = byteVal[4:0];
  y = byteVal[7:5];
  if (isK && (x == 5'd28))
    six = K28_SIX_NEG;
  else
    six = SIX_NEG_TABLE[(31 - int'(x)) * 6 +: 6];
  // Unbalanced blocks and D.7 take the RD+ column by inversion
  if (rdIn && (($countones(six) != 3) || (six == 6'b111000)))
    six = ~six;
  // Only an unbalanced block moves the disparity
  rdMid = ($countones(six) == 3) ? rdIn : ~rdIn;

  // Alternate .7 avoids a run of five at e i f g h
  useAlt = (!rdMid && ((x == 5'd17) || (x == 5'd18) || (x == 5'd20))) ||
           (rdMid && ((x == 5'd11) || (x == 5'd13) || (x == 5'd14)));
  if (isK)
    four = FOUR_K_NEG_TABLE[(7 - int'(y)) * 4 +: 4];
  else if ((y == 3'd7) && useAlt)
    four = ALT7_NEG;
  else
    four = FOUR_DATA_NEG_TABLE[(7 - int'(y)) * 4 +: 4];
  // All K blocks, unbalanced data blocks and D.x.3 depend on disparity
  if (rdMid && (isK || ($countones(four) != 2) || (four == 4'b1100)))
    four = ~four;
  rdOut = ($countones(four) == 2) ? rdMid : ~rdMid;
  return {six, four};
endfunction

`endif

// File: tbDecoder8b10b.sv
`timescale 1ns/10ps
`default_nettype none

`include "decoder8b10b_macros.svh"

module tbDecoder8b10b;

  // D.10.2, balanced in both halves, leaves the disparity alone
  localparam logic [7:0]  IDLE_BYTE = 8'h4A;
  localparam logic [9:0]  IDLE_CODE = 10'b0101010101;
  // D.0.1 has one unbalanced block and flips the disparity
  localparam logic [7:0]  FLIP_BYTE = 8'h20;
  localparam int          WAIT_LIMIT = 20;
  // K28.0 to K28.7, then K23.7 K27.7 K29.7 K30.7
  localparam logic [95:0] K_CHARS = {
    8'h1C, 8'h3C, 8'h5C, 8'h7C, 8'h9C, 8'hBC, 8'hDC, 8'hFC, 8'hF7, 8'hFB, 8'hFD, 8'hFE
  };
  // abcd ones, abcd zeros, fghj ones, fghj zeros
  localparam logic [39:0] BAD_CODES = {
    10'b1111001001, 10'b0000110110, 10'b1100011111, 10'b1100010000
  };

  logic                   RBYTECLK;
  logic                   reset;
  logic [`TBI_WIDTH-1:0]  tbi;
  logic                   kOut;
  logic [`BYTE_WIDTH-1:0] ebi;
  logic                   codingErr;
  logic                   disparity;
  logic                   disparityErr;

  // Disparity of the reference encoder
  logic modelRd;

  // Expected response of the group in the DUT output register
  logic       pendValid;
  logic       pendCodingOnly;
  logic [9:0] pendCode;
  logic [7:0] pendByte;
  logic       pendK;
  logic       pendCErr;
  logic       pendDErr;
  logic       pendRd;

  int errCount;
  int checkCount;
  int testCount;
  int errMark;

  `include "tbCodeTables.svh"

  decoder8b10b uut (
    .RBYTECLK       (RBYTECLK),
    .reset          (reset),
    .tbi_i          (tbi),
    .kOut_o         (kOut),
    .ebi_o          (ebi),
    .codingErr_o    (codingErr),
    .disparity_o    (disparity),
    .disparityErr_o (disparityErr)
  );

  always
  begin
    #5 RBYTECLK = ~RBYTECLK;
  end

  // ************************************************************
  // Drive and check helpers
  // ************************************************************

  task automatic checkField(input string what, input logic [7:0] got, input logic [7:0] exp);
    checkCount++;
    assert (got === exp)
    else
    begin
      $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      errCount++;
    end
  endtask

  task automatic checkPending();
    if (pendValid)
    begin
      checkField($sformatf("coding_err for %b", pendCode), codingErr, pendCErr);
      if (!pendCodingOnly)
      begin
        checkField($sformatf("ebi for %b", pendCode), ebi, pendByte);
        checkField($sformatf("K_out for %b", pendCode), kOut, pendK);
        checkField($sformatf("disparity_err for %b", pendCode), disparityErr, pendDErr);
        checkField($sformatf("disparity for %b", pendCode), disparity, pendRd);
      end
    end
  endtask

  // Outputs at this negedge belong to the group of the previous call
  task automatic driveGroup(input logic [9:0] code, input logic [7:0] expByte,
                            input logic expK, input logic expCErr, input logic expDErr,
                            input logic expRd, input logic codingOnly);
    @(posedge RBYTECLK);
    tbi <= code;
    @(negedge RBYTECLK);
    checkPending();
    pendValid      = 1'b1;
    pendCodingOnly = codingOnly;
    pendCode       = code;
    pendByte       = expByte;
    pendK          = expK;
    pendCErr       = expCErr;
    pendDErr       = expDErr;
    pendRd         = expRd;
  endtask

  // Idle on the line while the last group is checked
  task automatic flushPipeline();
    @(posedge RBYTECLK);
    tbi <= IDLE_CODE;
    @(negedge RBYTECLK);
    checkPending();
    pendValid = 1'b0;
  endtask

  task automatic sendByte(input logic [7:0] byteVal, input logic isK);
    logic [9:0] code;
    logic       rdAfter;

    code = encodeGroup(byteVal, isK, modelRd, rdAfter);
    driveGroup(code, byteVal, isK, 1'b0, 1'b0, rdAfter, 1'b0);
    modelRd = rdAfter;
  endtask

  task automatic checkResetValues(input string phase);
    checkField({"K_out ", phase}, kOut, 8'h00);
    checkField({"ebi ", phase}, ebi, 8'h00);
    checkField({"disparity ", phase}, disparity, 8'h00);
    checkField({"coding_err ", phase}, codingErr, 8'h01);
    checkField({"disparity_err ", phase}, disparityErr, 8'h01);
  endtask

  task automatic waitErrorsClear();
    int cycles;

    cycles = 0;
    while ((codingErr || disparityErr) && (cycles < WAIT_LIMIT))
    begin
      @(negedge RBYTECLK);
      cycles++;
    end
    if (codingErr || disparityErr)
    begin
      $display("Timeout: error flags still set %0d cycles after reset release", WAIT_LIMIT);
      errCount++;
    end
  endtask

  task automatic reportTest(input string name, input int errBefore);
    testCount++;
    $display("Test %-22s done, %0d error(s)", name, errCount - errBefore);
  endtask

  // ************************************************************
  // Directed tests
  // ************************************************************

  // Four cycles low, release on the fourth edge
  task automatic resetSequence();
    repeat (3) @(posedge RBYTECLK);
    @(negedge RBYTECLK);
    checkResetValues("during reset");
    @(posedge RBYTECLK);
    reset <= 1'b1;
    @(negedge RBYTECLK);
    checkResetValues("after release");
    waitErrorsClear();
  endtask

  task automatic decodeRandomData();
    int n;

    for (n = 0; n < 64; n++)
      sendByte(nextRandomByte(), 1'b0);
    flushPipeline();
  endtask

  task automatic decodeControlChars();
    logic [7:0] kChar;
    int         n;
    int         pass;

    for (n = 0; n < 12; n++)
    begin
      kChar = K_CHARS[(11 - n) * 8 +: 8];
      // Each K character once from RD- and once from RD+
      for (pass = 0; pass < 2; pass++)
      begin
        if (modelRd != pass[0])
          sendByte(FLIP_BYTE, 1'b0);
        sendByte(kChar, 1'b1);
      end
    end
    flushPipeline();
  endtask

  task automatic flagWrongDisparity();
    logic [9:0] code;
    logic       rdAfter;
    int         n;

    for (n = 0; n < 2; n++)
    begin
      // D.0.0 from the opposite column, legal but wrong disparity
      code = encodeGroup(8'h00, 1'b0, ~modelRd, rdAfter);
      driveGroup(code, 8'h00, 1'b0, 1'b0, 1'b1, rdAfter, 1'b0);
      // Unbalanced fghj sets the line disparity on its own
      modelRd = rdAfter;
    end
    sendByte(nextRandomByte(), 1'b0);
    flushPipeline();
  endtask

  task automatic flagIllegalGroups();
    int n;

    for (n = 0; n < 4; n++)
    begin
      driveGroup(BAD_CODES[(3 - n) * 10 +: 10], 8'h00, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
      // Flag drops again on a legal group
      driveGroup(IDLE_CODE, IDLE_BYTE, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    end
    flushPipeline();
  endtask

  initial
  begin
    RBYTECLK       = 1'b0;
    reset          = 1'b0;
    tbi            = IDLE_CODE;
    modelRd        = 1'b0;
    pendValid      = 1'b0;
    pendCodingOnly = 1'b0;
    pendCode       = '0;
    pendByte       = '0;
    pendK          = 1'b0;
    pendCErr       = 1'b0;
    pendDErr       = 1'b0;
    pendRd         = 1'b0;
    errCount       = 0;
    checkCount     = 0;
    testCount      = 0;

    errMark = errCount;
    resetSequence();
    reportTest("reset values", errMark);
    errMark = errCount;
    decodeRandomData();
    reportTest("data decode", errMark);
    errMark = errCount;
    decodeControlChars();
    reportTest("control characters", errMark);
    errMark = errCount;
    flagWrongDisparity();
    reportTest("disparity error", errMark);
    errMark = errCount;
    flagIllegalGroups();
    reportTest("coding error", errMark);

    $display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errCount);
    if (errCount == 0)
    begin
      $display("Simulation PASSED");
    end
    else
    begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
